// File: build.f
+incdir+verilog
verilog/panel_pkg.sv
verilog/cmd_dispatch.sv
verilog/fillrect_cmd.sv
verilog/fillarea_walker.sv
verilog/framebuffer.sv
verilog/panel_ctrl_top.sv
dv/panel_ctrl_props.sv
dv/panel_ctrl_tb.sv

// File: dv/panel_ctrl_tb.sv
// ######################################
// Directed testbench of the drawing engine,
// checked against a reference image
// ######################################
`timescale 1ns/1ns
`default_nettype none

`include "panel_settings.svh"

module panel_ctrl_tb;
    import panel_pkg::*;

    localparam int DEPTH = `PANEL_COLS * `PANEL_ROWS;
    localparam int TIMEOUT_CYCLES = 5000;

    logic        clk;
    logic        reset;
    logic [7:0]  cmd_data;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        cmd_done;
    logic        rd_en;
    pixel_addr_t rd_addr;
    color_t      rd_data;

    integer seed;
    int     done_count = 0;
    color_t ref_img [DEPTH];

    panel_ctrl_top UUT (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (cmd_data),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Completion pulses, counted mid-cycle
    always @(negedge clk) begin
        if (cmd_done === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    // ######################################
    // Helpers
    // ######################################
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_equal(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                                        test_name, expected, actual));
        end
    endtask

    function automatic fill_req_t make_rect(input xcoord_t x1, input ycoord_t y1,
                                            input xcoord_t width, input ycoord_t height,
                                            input color_t color);
        fill_req_t r;
        r.x1     = x1;
        r.y1     = y1;
        r.width  = width;
        r.height = height;
        r.color  = color;
        return r;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Called and left right after a falling edge
    task automatic send_byte(input logic [7:0] value);
        int gap;
        int waited;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        cmd_data  = value;
        cmd_valid = 1'b1;
        waited    = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_with_failure("Timed out waiting for cmd_ready on a command byte");
            end
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic read_pixel(input pixel_addr_t addr, output color_t value);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        value = rd_data;
        rd_en = 1'b0;
    endtask

    task automatic send_rect(input fill_req_t r);
        int i;
        send_byte(`OP_FILLRECT);
        for (i = `COORD_BYTES - 1; i >= 0; i--) begin
            send_byte(r.x1[i*8 +: 8]);
        end
        send_byte(r.y1);
        for (i = `COORD_BYTES - 1; i >= 0; i--) begin
            send_byte(r.width[i*8 +: 8]);
        end
        send_byte(r.height);
        for (i = `BYTES_PER_PIXEL - 1; i >= 0; i--) begin
            send_byte(r.color[i*8 +: 8]);
        end
    endtask

    // Reference model, end coordinates clamped to the panel
    task automatic model_fill(input fill_req_t r);
        int x_end;
        int y_end;
        x_end = int'(r.x1) + int'(r.width);
        y_end = int'(r.y1) + int'(r.height);
        if (x_end > `PANEL_COLS) x_end = `PANEL_COLS;
        if (y_end > `PANEL_ROWS) y_end = `PANEL_ROWS;
        for (int y = int'(r.y1); y < y_end; y++) begin
            for (int x = int'(r.x1); x < x_end; x++) begin
                ref_img[y * `PANEL_COLS + x] = r.color;
            end
        end
    endtask

    task automatic fill_rect(input fill_req_t r);
        send_rect(r);
        model_fill(r);
    endtask

    task automatic clear_panel();
        send_byte(`OP_CLEAR);
        for (int a = 0; a < DEPTH; a++) begin
            ref_img[a] = '0;
        end
    endtask

    task automatic wait_for_done(input int target, input bit check_busy);
        int waited;
        waited = 0;
        while (done_count != target) begin
            if (check_busy) begin
                check_equal("cmd_ready while busy", 0, cmd_ready);
            end
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_with_failure("Timed out waiting for cmd_done");
            end
        end
    endtask

    task automatic fill_and_wait(input fill_req_t r, input string test_name);
        int base;
        base = done_count;
        fill_rect(r);
        wait_for_done(base + 1, 1'b1);
        check_equal({test_name, " cmd_ready after done"}, 1, cmd_ready);
    endtask

    task automatic compare_image(input string test_name);
        color_t got;
        for (int a = 0; a < DEPTH; a++) begin
            read_pixel(pixel_addr_t'(a), got);
            check_equal(test_name, ref_img[a], got);
        end
    endtask

    // ######################################
    // Directed tests
    // ######################################
    task automatic reset_and_clear();
        int base;
        check_equal("reset cmd_ready", 1, cmd_ready);
        check_equal("reset cmd_done", 0, cmd_done);
        base = done_count;
        clear_panel();
        wait_for_done(base + 1, 1'b1);
        check_equal("clear cmd_ready", 1, cmd_ready);
        idle_cycles(4);
        check_equal("clear done count", base + 1, done_count);
        compare_image("clear image");
    endtask

    task automatic inside_fill();
        // x1 of 0x0011 only lands on the panel when sent MSB first
        fill_and_wait(make_rect(16'h0011, 8'd4, 16'h000C, 8'd9, 16'hA53C), "inside_fill");
        compare_image("inside_fill image");
    endtask

    task automatic edge_clipping();
        fill_and_wait(make_rect(16'd56, 8'd28, 16'd20, 8'd10, 16'h1234), "clip right bottom");
        fill_and_wait(make_rect(16'h0100, 8'd2, 16'd8, 8'd3, 16'h7E7E), "clip far x1");
        fill_and_wait(make_rect(16'd64, 8'd0, 16'd4, 8'd4, 16'h3C3C), "clip x1 at edge");
        compare_image("edge_clipping image");
    endtask

    task automatic empty_and_unknown();
        int base;
        fill_and_wait(make_rect(16'd10, 8'd10, 16'd0, 8'd5, 16'hFFFF), "zero width");
        fill_and_wait(make_rect(16'd10, 8'd10, 16'd5, 8'd0, 16'hFFFF), "zero height");
        compare_image("zero size image");
        base = done_count;
        send_byte(8'h7F);
        idle_cycles(20);
        check_equal("unknown opcode done count", base, done_count);
        check_equal("unknown opcode cmd_ready", 1, cmd_ready);
        fill_and_wait(make_rect(16'd3, 8'd3, 16'd2, 8'd2, 16'h0F0F), "after unknown");
        compare_image("after unknown image");
    endtask

    task automatic fill_under_reads();
        fill_req_t r;
        int base;
        base = done_count;
        r = make_rect(16'd0, 8'd0, 16'd64, 8'd32, 16'h5AA5);
        send_rect(r);
        // No write gets through, so the first pixels of the area keep the old image
        for (int i = 0; i < 200; i++) begin
            rd_en   = 1'b1;
            rd_addr = pixel_addr_t'(i % 4);
            @(negedge clk);
            check_equal("stalled read data", ref_img[i % 4], rd_data);
            check_equal("stalled cmd_ready", 0, cmd_ready);
            check_equal("stalled done count", base, done_count);
        end
        rd_en = 1'b0;
        model_fill(r);
        wait_for_done(base + 1, 1'b1);
        check_equal("fill_under_reads cmd_ready after done", 1, cmd_ready);
        compare_image("fill_under_reads image");
    endtask

    task automatic back_to_back();
        int base;
        base = done_count;
        clear_panel();
        fill_rect(make_rect(16'd5, 8'd6, 16'd30, 8'd12, 16'hC0DE));
        fill_rect(make_rect(16'd20, 8'd10, 16'd50, 8'd30, 16'h0BAD));
        wait_for_done(base + 3, 1'b0);
        idle_cycles(10);
        check_equal("back_to_back done count", base + 3, done_count);
        compare_image("back_to_back image");
    endtask

    initial begin
        reset     = 1'b1;
        cmd_data  = '0;
        cmd_valid = 1'b0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        seed      = 9964;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        reset_and_clear();
        inside_fill();
        edge_clipping();
        empty_and_unknown();
        fill_under_reads();
        back_to_back();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/panel_ctrl_props.sv
// ######################################
// Handshake and completion assertions,
// bound into the drawing engine top level
// ######################################
`timescale 1ns/1ns
`default_nettype none

module panel_ctrl_props (
    input wire                       clk,
    input wire                       reset,
    input wire [7:0]                 cmd_data,
    input wire                       cmd_valid,
    input wire                       cmd_ready,
    input wire                       cmd_done,
    input wire panel_pkg::fb_write_t wr,
    input wire                       wr_valid,
    input wire                       wr_ready
);

    // Stalled transfers keep their payload
    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
        else $error("command byte changed while stalled");

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr))
        else $error("framebuffer write changed while stalled");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        cmd_done |=> !cmd_done)
        else $error("cmd_done longer than one cycle");

    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        cmd_done |-> !cmd_ready)
        else $error("cmd_ready high together with cmd_done");

    // Next opcode accepted right after the completion
    a_done_release: assert property (@(posedge clk) disable iff (reset)
        cmd_done |=> cmd_ready)
        else $error("cmd_ready still low the cycle after cmd_done");

    a_wr_known: assert property (@(posedge clk) disable iff (reset)
        wr_valid |-> !$isunknown(wr))
        else $error("framebuffer write with unknown address or colour");

endmodule

bind panel_ctrl_top panel_ctrl_props u_props (
    .clk       (clk),
    .reset     (reset),
    .cmd_data  (cmd_data),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_done  (cmd_done),
    .wr        (wr),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready)
);

`default_nettype wire

// File: verilog/panel_ctrl_top.sv
// ######################################
// Drawing engine top level
// ######################################
`timescale 1ns/1ns
`default_nettype none

module panel_ctrl_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [7:0]                   cmd_data,
    input  wire                         cmd_valid,
    output logic                        cmd_ready,
    output logic                        cmd_done,
    input  wire                         rd_en,
    input  wire panel_pkg::pixel_addr_t rd_addr,
    output panel_pkg::color_t           rd_data
);
    import panel_pkg::*;

    logic [7:0] arg_data;
    logic arg_valid;
    logic arg_ready;
    fill_req_t rect_req;
    logic rect_req_valid;
    logic rect_req_ready;
    logic rect_done;
    fill_req_t req;
    logic req_valid;
    logic req_ready;
    logic fill_done;
    fb_write_t wr;
    logic wr_valid;
    logic wr_ready;

    cmd_dispatch u_dispatch (
        .clk            (clk),
        .reset          (reset),
        .cmd_data       (cmd_data),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .arg_data       (arg_data),
        .arg_valid      (arg_valid),
        .arg_ready      (arg_ready),
        .rect_req       (rect_req),
        .rect_req_valid (rect_req_valid),
        .rect_req_ready (rect_req_ready),
        .req            (req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .fill_done      (fill_done),
        .rect_done      (rect_done),
        .cmd_done       (cmd_done)
    );

    fillrect_cmd u_fillrect (
        .clk            (clk),
        .reset          (reset),
        .arg_data       (arg_data),
        .arg_valid      (arg_valid),
        .arg_ready      (arg_ready),
        .rect_req       (rect_req),
        .rect_req_valid (rect_req_valid),
        .rect_req_ready (rect_req_ready),
        .rect_done      (rect_done)
    );

    fillarea_walker u_walker (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .fill_done (fill_done)
    );

    framebuffer u_fb (
        .clk      (clk),
        .wr       (wr),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// File: verilog/framebuffer.sv
// ######################################
// Pixel memory with one port; a read wins the
// port and holds off the write for that cycle
// ######################################
`timescale 1ns/1ns
`default_nettype none

`include "panel_settings.svh"

module framebuffer (
    input  wire                         clk,
    input  wire panel_pkg::fb_write_t   wr,
    input  wire                         wr_valid,
    output logic                        wr_ready,
    input  wire                         rd_en,
    input  wire panel_pkg::pixel_addr_t rd_addr,
    output panel_pkg::color_t           rd_data
);
    import panel_pkg::*;

    localparam int unsigned DEPTH = `PANEL_COLS * `PANEL_ROWS;

    // Contents undefined until the first clear
    color_t mem [DEPTH];

    // Scan-out reads have priority
    assign wr_ready = !rd_en;

    // Read data appears the cycle after rd_en and holds otherwise
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end else if (wr_valid) begin
            mem[wr.addr] <= wr.color;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fillarea_walker.sv
// ######################################
// Clips a fill request to the panel and writes
// each covered pixel, one per accepted write
// ######################################
`timescale 1ns/1ns
`default_nettype none

`include "panel_settings.svh"

module fillarea_walker (
    input  wire                       clk,
    input  wire                       reset,
    input  wire panel_pkg::fill_req_t req,
    input  wire                       req_valid,
    output logic                      req_ready,
    output panel_pkg::fb_write_t      wr,
    output logic                      wr_valid,
    input  wire                       wr_ready,
    output logic                      fill_done
);
    import panel_pkg::*;

    // One extra bit so that start plus size cannot wrap
    localparam int unsigned XSUM_W = $bits(xcoord_t) + 1;
    localparam int unsigned YSUM_W = $bits(ycoord_t) + 1;

    logic [XSUM_W-1:0] x_sum;
    logic [XSUM_W-1:0] x_lim;
    logic [YSUM_W-1:0] y_sum;
    logic [YSUM_W-1:0] y_lim;
    logic area_empty;
    logic empty_pend;
    logic req_take;
    logic last_pixel;
    col_addr_t col;
    col_addr_t x_start;
    col_addr_t x_last;
    row_addr_t row;
    row_addr_t y_last;
    color_t fill_color;

    // Clip to the panel, end coordinates exclusive
    always_comb begin
        x_sum = XSUM_W'(req.x1) + XSUM_W'(req.width);
        y_sum = YSUM_W'(req.y1) + YSUM_W'(req.height);
        x_lim = (x_sum > XSUM_W'(`PANEL_COLS)) ? XSUM_W'(`PANEL_COLS) : x_sum;
        y_lim = (y_sum > YSUM_W'(`PANEL_ROWS)) ? YSUM_W'(`PANEL_ROWS) : y_sum;
        // Covers zero size and a start past the edge
        area_empty = (x_lim <= XSUM_W'(req.x1)) || (y_lim <= YSUM_W'(req.y1));
    end

    assign req_ready  = !wr_valid && !empty_pend;
    assign req_take   = req_valid && req_ready;
    assign last_pixel = (col == x_last) && (row == y_last);

    assign wr = '{
        addr:  pixel_addr_t'(pixel_addr_t'(row) * `PANEL_COLS + pixel_addr_t'(col)),
        color: fill_color
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid   <= 1'b0;
            empty_pend <= 1'b0;
            fill_done  <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (req_take) begin
                if (area_empty) begin
                    empty_pend <= 1'b1;
                end else begin
                    wr_valid <= 1'b1;
                end
            end
            if (empty_pend) begin
                empty_pend <= 1'b0;
                fill_done  <= 1'b1;
            end
            if (wr_valid && wr_ready && last_pixel) begin
                wr_valid  <= 1'b0;
                fill_done <= 1'b1;
            end
        end
    end

    // Walk counters, stepped only on an accepted write
    always_ff @(posedge clk) begin
        if (req_take) begin
            x_start    <= col_addr_t'(req.x1);
            col        <= col_addr_t'(req.x1);
            row        <= row_addr_t'(req.y1);
            x_last     <= col_addr_t'(x_lim - 1'b1);
            y_last     <= row_addr_t'(y_lim - 1'b1);
            fill_color <= req.color;
        end else if (wr_valid && wr_ready) begin
            if (col == x_last) begin
                col <= x_start;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fillrect_cmd.sv
// ######################################
// Fill-rectangle argument capture; builds one fill
// request and waits for it to complete
// ######################################
`timescale 1ns/1ns
`default_nettype none

`include "panel_settings.svh"

module fillrect_cmd (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [7:0]            arg_data,
    input  wire                  arg_valid,
    output logic                 arg_ready,
    output panel_pkg::fill_req_t rect_req,
    output logic                 rect_req_valid,
    input  wire                  rect_req_ready,
    input  wire                  rect_done
);
    import panel_pkg::*;

    // Wide enough for any multibyte field
    localparam int unsigned CNT_W = 4;

    fillrect_state_t state;
    logic [CNT_W-1:0] byte_left;
    xcoord_t x1;
    xcoord_t width;
    ycoord_t y1;
    ycoord_t height;
    color_t color;
    logic arg_take;

    assign arg_ready = (state == FR_X1) || (state == FR_Y1) || (state == FR_WIDTH) ||
                       (state == FR_HEIGHT) || (state == FR_COLOR);
    assign arg_take  = arg_valid && arg_ready;

    assign rect_req_valid = (state == FR_REQ);
    assign rect_req = '{
        x1:     x1,
        y1:     y1,
        width:  width,
        height: height,
        color:  color
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FR_X1;
            byte_left <= CNT_W'(`COORD_BYTES - 1);
            x1        <= '0;
            y1        <= '0;
            width     <= '0;
            height    <= '0;
            color     <= '0;
        end else begin
            case (state)
                FR_X1: begin
                    if (arg_take) begin
                        // Most significant byte arrives first
                        x1 <= xcoord_t'({x1, arg_data});
                        if (byte_left == '0) begin
                            state <= FR_Y1;
                        end else begin
                            byte_left <= byte_left - 1'b1;
                        end
                    end
                end
                FR_Y1: begin
                    if (arg_take) begin
                        y1        <= arg_data;
                        byte_left <= CNT_W'(`COORD_BYTES - 1);
                        state     <= FR_WIDTH;
                    end
                end
                FR_WIDTH: begin
                    if (arg_take) begin
                        width <= xcoord_t'({width, arg_data});
                        if (byte_left == '0) begin
                            state <= FR_HEIGHT;
                        end else begin
                            byte_left <= byte_left - 1'b1;
                        end
                    end
                end
                FR_HEIGHT: begin
                    if (arg_take) begin
                        height    <= arg_data;
                        byte_left <= CNT_W'(`BYTES_PER_PIXEL - 1);
                        state     <= FR_COLOR;
                    end
                end
                FR_COLOR: begin
                    if (arg_take) begin
                        color <= color_t'({color, arg_data});
                        if (byte_left == '0) begin
                            state <= FR_REQ;
                        end else begin
                            byte_left <= byte_left - 1'b1;
                        end
                    end
                end
                FR_REQ: begin
                    if (rect_req_ready) begin
                        state <= FR_WAIT;
                    end
                end
                FR_WAIT: begin
                    // Back to a clean slate for the next rectangle
                    if (rect_done) begin
                        state     <= FR_X1;
                        byte_left <= CNT_W'(`COORD_BYTES - 1);
                        x1        <= '0;
                        y1        <= '0;
                        width     <= '0;
                        height    <= '0;
                        color     <= '0;
                    end
                end
                default: state <= FR_X1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmd_dispatch.sv
// ######################################
// Opcode decoder of the command stream; forwards fill
// arguments, issues clears and reports completion
// ######################################
`timescale 1ns/1ns
`default_nettype none

`include "panel_settings.svh"

module cmd_dispatch (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [7:0]               cmd_data,
    input  wire                     cmd_valid,
    output logic                    cmd_ready,
    output logic [7:0]              arg_data,
    output logic                    arg_valid,
    input  wire                     arg_ready,
    input  wire panel_pkg::fill_req_t rect_req,
    input  wire                     rect_req_valid,
    output logic                    rect_req_ready,
    output panel_pkg::fill_req_t    req,
    output logic                    req_valid,
    input  wire                     req_ready,
    input  wire                     fill_done,
    output logic                    rect_done,
    output logic                    cmd_done
);
    import panel_pkg::*;

    // Whole panel in colour zero
    localparam fill_req_t CLEAR_REQ = '{
        x1:     '0,
        y1:     '0,
        width:  xcoord_t'(`PANEL_COLS),
        height: ycoord_t'(`PANEL_ROWS),
        color:  '0
    };

    dispatch_state_t state;

    // ######################################
    // Stream and request routing
    // ######################################
    assign arg_data  = cmd_data;
    assign arg_valid = cmd_valid && (state == DS_FILL_ARGS);

    always_comb begin
        case (state)
            DS_OPCODE:    cmd_ready = 1'b1;
            DS_FILL_ARGS: cmd_ready = arg_ready;
            default:      cmd_ready = 1'b0;
        endcase
    end

    always_comb begin
        req            = rect_req;
        req_valid      = 1'b0;
        rect_req_ready = 1'b0;
        if (state == DS_FILL_ARGS) begin
            req_valid      = rect_req_valid;
            rect_req_ready = req_ready;
        end else if (state == DS_CLEAR_REQ) begin
            req       = CLEAR_REQ;
            req_valid = 1'b1;
        end
    end

    // Completion goes back to the fill capture only when it owns the request
    assign rect_done = fill_done && (state == DS_FILL_WAIT);

    // ######################################
    // Command FSM
    // ######################################
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DS_OPCODE;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                DS_OPCODE: begin
                    if (cmd_valid) begin
                        if (cmd_data == `OP_FILLRECT) begin
                            state <= DS_FILL_ARGS;
                        end else if (cmd_data == `OP_CLEAR) begin
                            state <= DS_CLEAR_REQ;
                        end
                    end
                end
                DS_FILL_ARGS: begin
                    if (rect_req_valid && req_ready) begin
                        state <= DS_FILL_WAIT;
                    end
                end
                DS_CLEAR_REQ: begin
                    if (req_ready) begin
                        state <= DS_CLEAR_WAIT;
                    end
                end
                DS_FILL_WAIT, DS_CLEAR_WAIT: begin
                    if (fill_done) begin
                        cmd_done <= 1'b1;
                        state    <= DS_DONE;
                    end
                end
                // Hold off the next opcode for the cmd_done cycle
                default: state <= DS_OPCODE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/panel_pkg.sv
// ######################################
// Shared types of the drawing engine
// ######################################
`default_nettype none

`include "panel_settings.svh"

package panel_pkg;

    // Panel addresses
    typedef logic [$clog2(`PANEL_COLS)-1:0] col_addr_t;
    typedef logic [$clog2(`PANEL_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(`PANEL_COLS * `PANEL_ROWS)-1:0] pixel_addr_t;

    // Fields as they arrive from the command stream
    typedef logic [`COORD_BYTES*8-1:0] xcoord_t;
    typedef logic [7:0] ycoord_t;
    typedef logic [`BYTES_PER_PIXEL*8-1:0] color_t;

    typedef struct packed {
        xcoord_t x1;
        ycoord_t y1;
        xcoord_t width;
        ycoord_t height;
        color_t  color;
    } fill_req_t;

    typedef struct packed {
        pixel_addr_t addr;
        color_t      color;
    } fb_write_t;

    typedef enum logic [2:0] {
        FR_X1,
        FR_Y1,
        FR_WIDTH,
        FR_HEIGHT,
        FR_COLOR,
        FR_REQ,
        FR_WAIT
    } fillrect_state_t;

    typedef enum logic [2:0] {
        DS_OPCODE,
        DS_FILL_ARGS,
        DS_FILL_WAIT,
        DS_CLEAR_REQ,
        DS_CLEAR_WAIT,
        DS_DONE
    } dispatch_state_t;

endpackage

`default_nettype wire

// File: verilog/panel_settings.svh
// ######################################
// Panel geometry, wire format and opcodes
// for the drawing engine, included where needed
// ######################################
`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// Panel size in pixels
`define PANEL_COLS 64
`define PANEL_ROWS 32

// Colour bytes per pixel, sent most significant first
`define BYTES_PER_PIXEL 2

// Wire bytes for x1 and width, most significant first
`define COORD_BYTES 2

// Command opcodes
`define OP_FILLRECT 8'h01
`define OP_CLEAR 8'h02

`endif
